/* hw/bus_arbiter.sv */
`default_nettype none
`timescale 1ns/100ps

module bus_arbiter
    import mem_bridge_pkg::*;
#(
    parameter int unsigned RESP_DEPTH = 2
) (
    input  wire logic                                   clk_i,
    input  wire logic                                   rst_ni,

    // Port-side requests indexed by port number
    input  wire logic [NUM_PORTS-1:0]                   req_valid_i,
    output logic [NUM_PORTS-1:0]                        req_ready_o,
    input  wire logic [NUM_PORTS-1:0][ADDR_W-1:0]       req_addr_i,
    input  wire bus_op_e   [NUM_PORTS-1:0]              req_op_i,
    input  wire bus_size_e [NUM_PORTS-1:0]              req_size_i,
    input  wire logic [NUM_PORTS-1:0][BUS_DATA_W-1:0]   req_wdata_i,
    input  wire logic [NUM_PORTS-1:0][BUS_STRB_W-1:0]   req_strb_i,

    // Port-side responses
    output logic [NUM_PORTS-1:0]                        rsp_valid_o,
    input  wire logic [NUM_PORTS-1:0]                   rsp_ready_i,
    output logic [NUM_PORTS-1:0][BUS_DATA_W-1:0]        rsp_rdata_o,
    output logic [NUM_PORTS-1:0]                        rsp_err_o,

    // Shared bus
    output logic                                        bus_q_valid_o,
    input  wire logic                                   bus_q_ready_i,
    output logic [ADDR_W-1:0]                           bus_q_addr_o,
    output bus_op_e                                     bus_q_op_o,
    output bus_size_e                                   bus_q_size_o,
    output logic [BUS_DATA_W-1:0]                       bus_q_wdata_o,
    output logic [BUS_STRB_W-1:0]                       bus_q_strb_o,
    input  wire logic                                   bus_p_valid_i,
    output logic                                        bus_p_ready_o,
    input  wire logic [BUS_DATA_W-1:0]                  bus_p_rdata_i,
    input  wire logic                                   bus_p_err_i
);

    localparam int unsigned IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int unsigned PTR_W = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(RESP_DEPTH + 1);

    logic [IDX_W-1:0] last_q;
    logic             lock_q;
    logic [IDX_W-1:0] rr_pick;
    logic [IDX_W-1:0] sel;
    logic             push;
    logic             pop;

    logic [IDX_W-1:0] idx_fifo_q [RESP_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             q_full;
    logic             q_empty;
    logic [IDX_W-1:0] q_head;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (32'(ptr) == RESP_DEPTH - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // --------------------
    // Request arbitration
    // --------------------

    // Search starts at the port after the last grant
    always_comb begin
        int unsigned cand;
        logic        found;
        rr_pick = last_q;
        found   = 1'b0;
        for (int unsigned i = 1; i <= NUM_PORTS; i++) begin
            cand = (32'(last_q) + i) % NUM_PORTS;
            if (!found && req_valid_i[cand]) begin
                rr_pick = IDX_W'(cand);
                found   = 1'b1;
            end
        end
    end

    // A stalled grant stays put until the bus takes it
    assign sel = lock_q ? last_q : rr_pick;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lock_q <= 1'b0;
            last_q <= IDX_W'(NUM_PORTS - 1);
        end else begin
            lock_q <= bus_q_valid_o & ~bus_q_ready_i;
            if (bus_q_valid_o) begin
                last_q <= sel;
            end
        end
    end

    // Held back while there is no room to remember who gets the response
    assign bus_q_valid_o = req_valid_i[sel] & ~q_full;
    assign bus_q_addr_o  = req_addr_i[sel];
    assign bus_q_op_o    = req_op_i[sel];
    assign bus_q_size_o  = req_size_i[sel];
    assign bus_q_wdata_o = req_wdata_i[sel];
    assign bus_q_strb_o  = req_strb_i[sel];

    // --------------------
    // Response index queue
    // --------------------

    assign push    = bus_q_valid_o & bus_q_ready_i;
    assign pop     = bus_p_valid_i & bus_p_ready_o;
    assign q_full  = (count_q == CNT_W'(RESP_DEPTH));
    assign q_empty = (count_q == '0);
    assign q_head  = idx_fifo_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + CNT_W'(1);
            end else if (pop && !push) begin
                count_q <= count_q - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            idx_fifo_q[wr_ptr_q] <= sel;
        end
    end

    // Oldest outstanding port owns the response channel
    assign bus_p_ready_o = ~q_empty & rsp_ready_i[q_head];

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
        assign req_ready_o[g] = (sel == IDX_W'(g)) & bus_q_ready_i & ~q_full;
        assign rsp_valid_o[g] = bus_p_valid_i & ~q_empty & (q_head == IDX_W'(g));
        assign rsp_rdata_o[g] = bus_p_rdata_i;
        assign rsp_err_o[g]   = bus_p_err_i;
    end

endmodule

`default_nettype wire

/* hw/data_access_adapter.sv */
`default_nettype none
`timescale 1ns/100ps

module data_access_adapter
    import mem_bridge_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    // Core-side load/store port
    input  wire logic                   data_req_i,
    input  wire logic                   data_we_i,
    input  wire logic [ADDR_W-1:0]      data_addr_i,
    input  wire logic [CORE_DATA_W-1:0] data_wdata_i,
    input  wire logic [CORE_STRB_W-1:0] data_strb_i,
    output logic                        data_ack_o,
    output logic [CORE_DATA_W-1:0]      data_rdata_o,
    output logic                        data_err_o,

    // Bus request channel
    output logic                        q_valid_o,
    input  wire logic                   q_ready_i,
    output logic [ADDR_W-1:0]           q_addr_o,
    output bus_op_e                     q_op_o,
    output bus_size_e                   q_size_o,
    output logic [BUS_DATA_W-1:0]       q_wdata_o,
    output logic [BUS_STRB_W-1:0]       q_strb_o,

    // Bus response channel
    input  wire logic                   p_valid_i,
    output logic                        p_ready_o,
    input  wire logic [BUS_DATA_W-1:0]  p_rdata_i,
    input  wire logic                   p_err_i
);

    logic pending_q;
    logic upper_lane;

    // Busy from request acceptance until the response comes back
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (q_valid_o && q_ready_i) begin
            pending_q <= 1'b1;
        end else if (p_valid_i && p_ready_o) begin
            pending_q <= 1'b0;
        end
    end

    assign upper_lane = data_addr_i[2];

    // --------------------
    // Request
    // --------------------

    // Straight from req, no extra cycle
    assign q_valid_o = data_req_i & ~pending_q;
    assign q_addr_o  = {data_addr_i[ADDR_W-1:2], 2'b00};
    assign q_op_o    = data_we_i ? BUS_WRITE : BUS_READ;
    assign q_size_o  = BUS_SIZE_WORD;

    // Place the word in the lane that address bit 2 selects
    assign q_wdata_o = upper_lane ? {data_wdata_i, {CORE_DATA_W{1'b0}}}
                                  : {{CORE_DATA_W{1'b0}}, data_wdata_i};
    assign q_strb_o  = upper_lane ? {data_strb_i, {CORE_STRB_W{1'b0}}}
                                  : {{CORE_STRB_W{1'b0}}, data_strb_i};

    // --------------------
    // Response
    // --------------------

    assign p_ready_o    = data_req_i;
    assign data_ack_o   = p_valid_i & p_ready_o;
    assign data_rdata_o = upper_lane ? p_rdata_i[BUS_DATA_W-1:CORE_DATA_W]
                                     : p_rdata_i[CORE_DATA_W-1:0];
    assign data_err_o   = p_err_i;

endmodule

`default_nettype wire

/* hw/inst_fetch_adapter.sv */
`default_nettype none
`timescale 1ns/100ps

module inst_fetch_adapter
    import mem_bridge_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    // Core-side fetch port
    input  wire logic                   inst_req_i,
    input  wire logic [ADDR_W-1:0]      inst_addr_i,
    output logic                        inst_ack_o,
    output logic [CORE_DATA_W-1:0]      inst_rdata_o,

    // Bus request channel
    output logic                        q_valid_o,
    input  wire logic                   q_ready_i,
    output logic [ADDR_W-1:0]           q_addr_o,
    output bus_op_e                     q_op_o,
    output bus_size_e                   q_size_o,

    // Bus response channel
    input  wire logic                   p_valid_i,
    output logic                        p_ready_o,
    input  wire logic [BUS_DATA_W-1:0]  p_rdata_i
);

    logic              q_hs;
    logic              p_hs;
    logic              pending_q;
    logic              q_valid_q;
    logic [ADDR_W-1:0] addr_q;
    logic              high_q;

    assign q_hs = q_valid_o & q_ready_i;
    assign p_hs = p_valid_i & p_ready_o;

    // Only one fetch in flight, set on acceptance and cleared by the response
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (q_hs) begin
            pending_q <= 1'b1;
        end else if (p_hs) begin
            pending_q <= 1'b0;
        end
    end

    // Request goes out one cycle after req is seen with nothing pending
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            q_valid_q <= 1'b0;
        end else if (q_hs || pending_q) begin
            q_valid_q <= 1'b0;
        end else if (inst_req_i) begin
            q_valid_q <= 1'b1;
        end
    end

    // Capture once per fetch so the payload holds while valid is up
    always_ff @(posedge clk_i) begin
        if (inst_req_i && !q_valid_q && !pending_q) begin
            addr_q <= {inst_addr_i[ADDR_W-1:3], 3'b000};
            high_q <= inst_addr_i[2];
        end
    end

    // --------------------
    // Bus side
    // --------------------

    // Always a full aligned doubleword read
    assign q_valid_o = q_valid_q;
    assign q_addr_o  = addr_q;
    assign q_op_o    = BUS_READ;
    assign q_size_o  = BUS_SIZE_DWORD;
    assign p_ready_o = 1'b1;

    // Address bit 2 picks the half
    assign inst_ack_o   = p_hs;
    assign inst_rdata_o = high_q ? p_rdata_i[BUS_DATA_W-1:CORE_DATA_W]
                                 : p_rdata_i[CORE_DATA_W-1:0];

endmodule

`default_nettype wire

/* hw/mem_bridge_pkg.sv */
`default_nettype none

package mem_bridge_pkg;

    // --------------------
    // Widths
    // --------------------

    // Byte address, one word wide
    localparam int unsigned ADDR_W = 32;

    // Core side is 32-bit, the shared bus is 64-bit
    localparam int unsigned CORE_DATA_W = 32;
    localparam int unsigned BUS_DATA_W  = 64;

    // One strobe bit per byte lane
    localparam int unsigned CORE_STRB_W = CORE_DATA_W / 8;
    localparam int unsigned BUS_STRB_W  = BUS_DATA_W / 8;

    // Requesters on the arbiter, port 0 is data and port 1 is instruction
    localparam int unsigned NUM_PORTS = 2;

    // --------------------
    // Bus encodings
    // --------------------

    typedef enum logic [0:0] {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_op_e;

    // Size is log2 of the byte count
    typedef enum logic [1:0] {
        BUS_SIZE_WORD  = 2'd2,
        BUS_SIZE_DWORD = 2'd3
    } bus_size_e;

endpackage

`default_nettype wire

/* hw/mem_bridge_top.sv */
`default_nettype none
`timescale 1ns/100ps

module mem_bridge_top
    import mem_bridge_pkg::*;
#(
    parameter int unsigned RESP_DEPTH = 2
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    // Instruction fetch port
    input  wire logic                   inst_req_i,
    input  wire logic [ADDR_W-1:0]      inst_addr_i,
    output logic                        inst_ack_o,
    output logic [CORE_DATA_W-1:0]      inst_rdata_o,

    // Load/store port
    input  wire logic                   data_req_i,
    input  wire logic                   data_we_i,
    input  wire logic [ADDR_W-1:0]      data_addr_i,
    input  wire logic [CORE_DATA_W-1:0] data_wdata_i,
    input  wire logic [CORE_STRB_W-1:0] data_strb_i,
    output logic                        data_ack_o,
    output logic [CORE_DATA_W-1:0]      data_rdata_o,
    output logic                        data_err_o,

    // Master bus
    output logic                        bus_q_valid_o,
    input  wire logic                   bus_q_ready_i,
    output logic [ADDR_W-1:0]           bus_q_addr_o,
    output bus_op_e                     bus_q_op_o,
    output bus_size_e                   bus_q_size_o,
    output logic [BUS_DATA_W-1:0]       bus_q_wdata_o,
    output logic [BUS_STRB_W-1:0]       bus_q_strb_o,
    input  wire logic                   bus_p_valid_i,
    output logic                        bus_p_ready_o,
    input  wire logic [BUS_DATA_W-1:0]  bus_p_rdata_i,
    input  wire logic                   bus_p_err_i
);

    localparam int unsigned DATA_PORT = 0;
    localparam int unsigned INST_PORT = 1;

    logic [NUM_PORTS-1:0]                 arb_req_valid;
    logic [NUM_PORTS-1:0]                 arb_req_ready;
    logic [NUM_PORTS-1:0][ADDR_W-1:0]     arb_req_addr;
    bus_op_e   [NUM_PORTS-1:0]            arb_req_op;
    bus_size_e [NUM_PORTS-1:0]            arb_req_size;
    logic [NUM_PORTS-1:0][BUS_DATA_W-1:0] arb_req_wdata;
    logic [NUM_PORTS-1:0][BUS_STRB_W-1:0] arb_req_strb;
    logic [NUM_PORTS-1:0]                 arb_rsp_valid;
    logic [NUM_PORTS-1:0]                 arb_rsp_ready;
    logic [NUM_PORTS-1:0][BUS_DATA_W-1:0] arb_rsp_rdata;
    logic [NUM_PORTS-1:0]                 arb_rsp_err;

    // Fetches never write
    assign arb_req_wdata[INST_PORT] = '0;
    assign arb_req_strb[INST_PORT]  = '0;

    // --------------------
    // Adapters
    // --------------------

    inst_fetch_adapter u_inst_fetch_adapter (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .inst_req_i   (inst_req_i),
        .inst_addr_i  (inst_addr_i),
        .inst_ack_o   (inst_ack_o),
        .inst_rdata_o (inst_rdata_o),
        .q_valid_o    (arb_req_valid[INST_PORT]),
        .q_ready_i    (arb_req_ready[INST_PORT]),
        .q_addr_o     (arb_req_addr[INST_PORT]),
        .q_op_o       (arb_req_op[INST_PORT]),
        .q_size_o     (arb_req_size[INST_PORT]),
        .p_valid_i    (arb_rsp_valid[INST_PORT]),
        .p_ready_o    (arb_rsp_ready[INST_PORT]),
        .p_rdata_i    (arb_rsp_rdata[INST_PORT])
    );

    data_access_adapter u_data_access_adapter (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .data_req_i   (data_req_i),
        .data_we_i    (data_we_i),
        .data_addr_i  (data_addr_i),
        .data_wdata_i (data_wdata_i),
        .data_strb_i  (data_strb_i),
        .data_ack_o   (data_ack_o),
        .data_rdata_o (data_rdata_o),
        .data_err_o   (data_err_o),
        .q_valid_o    (arb_req_valid[DATA_PORT]),
        .q_ready_i    (arb_req_ready[DATA_PORT]),
        .q_addr_o     (arb_req_addr[DATA_PORT]),
        .q_op_o       (arb_req_op[DATA_PORT]),
        .q_size_o     (arb_req_size[DATA_PORT]),
        .q_wdata_o    (arb_req_wdata[DATA_PORT]),
        .q_strb_o     (arb_req_strb[DATA_PORT]),
        .p_valid_i    (arb_rsp_valid[DATA_PORT]),
        .p_ready_o    (arb_rsp_ready[DATA_PORT]),
        .p_rdata_i    (arb_rsp_rdata[DATA_PORT]),
        .p_err_i      (arb_rsp_err[DATA_PORT])
    );

    // --------------------
    // Merge onto the bus
    // --------------------

    bus_arbiter #(
        .RESP_DEPTH (RESP_DEPTH)
    ) u_bus_arbiter (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_valid_i   (arb_req_valid),
        .req_ready_o   (arb_req_ready),
        .req_addr_i    (arb_req_addr),
        .req_op_i      (arb_req_op),
        .req_size_i    (arb_req_size),
        .req_wdata_i   (arb_req_wdata),
        .req_strb_i    (arb_req_strb),
        .rsp_valid_o   (arb_rsp_valid),
        .rsp_ready_i   (arb_rsp_ready),
        .rsp_rdata_o   (arb_rsp_rdata),
        .rsp_err_o     (arb_rsp_err),
        .bus_q_valid_o (bus_q_valid_o),
        .bus_q_ready_i (bus_q_ready_i),
        .bus_q_addr_o  (bus_q_addr_o),
        .bus_q_op_o    (bus_q_op_o),
        .bus_q_size_o  (bus_q_size_o),
        .bus_q_wdata_o (bus_q_wdata_o),
        .bus_q_strb_o  (bus_q_strb_o),
        .bus_p_valid_i (bus_p_valid_i),
        .bus_p_ready_o (bus_p_ready_o),
        .bus_p_rdata_i (bus_p_rdata_i),
        .bus_p_err_i   (bus_p_err_i)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the memory bridge testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_mem_bridge \
    -f vlog.f \
    -o sim_tb_mem_bridge

sim_out=$(./obj_dir/sim_tb_mem_bridge)
echo "$sim_out"

# The run passes only if the testbench printed its pass line
if echo "$sim_out" | grep -qx "Simulation completed successfully"; then
    echo "run_sim: PASS"
    exit 0
fi

echo "run_sim: FAIL"
exit 1

/* testbench/tb_mem_bridge.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_mem_bridge
    import mem_bridge_pkg::*;
();

    localparam int          NUM_TESTS       = 6;
    localparam int          CYCLES_PER_TEST = 2000;
    localparam int          CONC_OPS        = 64;
    localparam logic [31:0] ERR_BASE        = 32'hF000_0000;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   inst_req_i;
    logic [ADDR_W-1:0]      inst_addr_i;
    logic                   inst_ack_o;
    logic [CORE_DATA_W-1:0] inst_rdata_o;
    logic                   data_req_i;
    logic                   data_we_i;
    logic [ADDR_W-1:0]      data_addr_i;
    logic [CORE_DATA_W-1:0] data_wdata_i;
    logic [CORE_STRB_W-1:0] data_strb_i;
    logic                   data_ack_o;
    logic [CORE_DATA_W-1:0] data_rdata_o;
    logic                   data_err_o;
    logic                   bus_q_valid_o;
    logic                   bus_q_ready_i;
    logic [ADDR_W-1:0]      bus_q_addr_o;
    bus_op_e                bus_q_op_o;
    bus_size_e              bus_q_size_o;
    logic [BUS_DATA_W-1:0]  bus_q_wdata_o;
    logic [BUS_STRB_W-1:0]  bus_q_strb_o;
    logic                   bus_p_valid_i;
    logic                   bus_p_ready_o;
    logic [BUS_DATA_W-1:0]  bus_p_rdata_i;
    logic                   bus_p_err_i;

    integer seed = 41;
    int     checks = 0;
    int     errors = 0;
    int     cyc;

    // Bus memory and the testbench's own view of what it should hold
    logic [63:0] mem     [logic [28:0]];
    logic [63:0] ref_mem [logic [28:0]];
    logic [63:0] rsp_data_q [$];
    logic        rsp_err_q  [$];
    int          rsp_at_q   [$];

    // Last request accepted on the bus
    logic [31:0] last_addr;
    bus_op_e     last_op;
    bus_size_e   last_size;
    logic [63:0] last_wdata;
    logic [7:0]  last_strb;

    mem_bridge_top #(
        .RESP_DEPTH (2)
    ) uut (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .inst_req_i    (inst_req_i),
        .inst_addr_i   (inst_addr_i),
        .inst_ack_o    (inst_ack_o),
        .inst_rdata_o  (inst_rdata_o),
        .data_req_i    (data_req_i),
        .data_we_i     (data_we_i),
        .data_addr_i   (data_addr_i),
        .data_wdata_i  (data_wdata_i),
        .data_strb_i   (data_strb_i),
        .data_ack_o    (data_ack_o),
        .data_rdata_o  (data_rdata_o),
        .data_err_o    (data_err_o),
        .bus_q_valid_o (bus_q_valid_o),
        .bus_q_ready_i (bus_q_ready_i),
        .bus_q_addr_o  (bus_q_addr_o),
        .bus_q_op_o    (bus_q_op_o),
        .bus_q_size_o  (bus_q_size_o),
        .bus_q_wdata_o (bus_q_wdata_o),
        .bus_q_strb_o  (bus_q_strb_o),
        .bus_p_valid_i (bus_p_valid_i),
        .bus_p_ready_o (bus_p_ready_o),
        .bus_p_rdata_i (bus_p_rdata_i),
        .bus_p_err_i   (bus_p_err_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // --------------------
    // Helpers
    // --------------------

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // Contents of a word nobody has written
    function automatic logic [63:0] fill_word(input logic [31:0] a);
        return {a ^ 32'hC3A5_5A3C, ~a};
    endfunction

    function automatic logic [63:0] ref_word(input logic [31:0] addr);
        if (ref_mem.exists(addr[31:3])) begin
            return ref_mem[addr[31:3]];
        end
        return fill_word({addr[31:3], 3'b000});
    endfunction

    // Merge a 32-bit store into the lane picked by address bit 2
    function automatic void ref_store(input logic [31:0] addr, input logic [31:0] wdata,
                                      input logic [3:0] strb);
        logic [63:0] w;
        int          base;
        w    = ref_word(addr);
        base = addr[2] ? 32 : 0;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[base + 8*b +: 8] = wdata[8*b +: 8];
            end
        end
        ref_mem[addr[31:3]] = w;
    endfunction

    task automatic preload(input logic [31:0] addr, input logic [63:0] word);
        mem[addr[31:3]]     = word;
        ref_mem[addr[31:3]] = word;
    endtask

    task automatic fetch_word(input logic [31:0] addr, output logic [31:0] rdata);
        @(posedge clk_i);
        #2;
        inst_req_i  = 1'b1;
        inst_addr_i = addr;
        do begin
            @(negedge clk_i);
        end while (!inst_ack_o);
        rdata = inst_rdata_o;
        @(posedge clk_i);
        #2;
        inst_req_i = 1'b0;
    endtask

    task automatic data_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strb,
                               output logic [31:0] rdata, output logic err);
        @(posedge clk_i);
        #2;
        data_req_i   = 1'b1;
        data_we_i    = we;
        data_addr_i  = addr;
        data_wdata_i = wdata;
        data_strb_i  = strb;
        do begin
            @(negedge clk_i);
        end while (!data_ack_o);
        rdata = data_rdata_o;
        err   = data_err_o;
        @(posedge clk_i);
        #2;
        data_req_i = 1'b0;
    endtask

    // --------------------
    // Bus memory model
    // --------------------

    // Drives ready and responses just after the edge
    initial begin : bus_driver
        logic [31:0] r;
        bus_q_ready_i = 1'b0;
        bus_p_valid_i = 1'b0;
        bus_p_rdata_i = '0;
        bus_p_err_i   = 1'b0;
        cyc           = 0;
        forever begin
            @(posedge clk_i);
            cyc++;
            #2;
            r = $random(seed);
            bus_q_ready_i = (r[1:0] != 2'b00);
            if (rsp_at_q.size() > 0 && cyc >= rsp_at_q[0]) begin
                bus_p_valid_i = 1'b1;
                bus_p_rdata_i = rsp_data_q[0];
                bus_p_err_i   = rsp_err_q[0];
            end else begin
                bus_p_valid_i = 1'b0;
                bus_p_rdata_i = '0;
                bus_p_err_i   = 1'b0;
            end
        end
    end

    // Handshakes are looked at mid-cycle, when everything has settled
    initial begin : bus_sampler
        logic [63:0] word;
        logic [31:0] r;
        logic        stalled;
        logic [31:0] stall_addr;
        stalled    = 1'b0;
        stall_addr = '0;
        forever begin
            @(negedge clk_i);
            if (stalled) begin
                check_value("bus_q_valid_o held", 64'(bus_q_valid_o), 64'd1);
                check_value("bus_q_addr_o held", 64'(bus_q_addr_o), 64'(stall_addr));
            end
            stalled    = rst_ni && bus_q_valid_o && !bus_q_ready_i;
            stall_addr = bus_q_addr_o;
            if (rst_ni && bus_p_valid_i && bus_p_ready_o) begin
                void'(rsp_data_q.pop_front());
                void'(rsp_err_q.pop_front());
                void'(rsp_at_q.pop_front());
            end
            if (rst_ni && bus_q_valid_o && bus_q_ready_i) begin
                last_addr  = bus_q_addr_o;
                last_op    = bus_q_op_o;
                last_size  = bus_q_size_o;
                last_wdata = bus_q_wdata_o;
                last_strb  = bus_q_strb_o;
                check_value("bus_q_addr_o alignment",
                            64'(bus_q_addr_o & ((32'd1 << bus_q_size_o) - 32'd1)), 64'd0);
                word = mem.exists(bus_q_addr_o[31:3]) ? mem[bus_q_addr_o[31:3]]
                                                      : fill_word({bus_q_addr_o[31:3], 3'b000});
                if (bus_q_addr_o >= ERR_BASE) begin
                    rsp_data_q.push_back(64'd0);
                    rsp_err_q.push_back(1'b1);
                end else if (bus_q_op_o == BUS_WRITE) begin
                    for (int b = 0; b < 8; b++) begin
                        if (bus_q_strb_o[b]) begin
                            word[8*b +: 8] = bus_q_wdata_o[8*b +: 8];
                        end
                    end
                    mem[bus_q_addr_o[31:3]] = word;
                    rsp_data_q.push_back(64'd0);
                    rsp_err_q.push_back(1'b0);
                end else begin
                    rsp_data_q.push_back(word);
                    rsp_err_q.push_back(1'b0);
                end
                r = $random(seed);
                rsp_at_q.push_back(cyc + 1 + int'(r[1:0]));
            end
        end
    end

    // --------------------
    // Directed tests
    // --------------------

    task automatic check_reset_idle();
        repeat (8) begin
            @(negedge clk_i);
            check_value("bus_q_valid_o", 64'(bus_q_valid_o), 64'd0);
            check_value("inst_ack_o", 64'(inst_ack_o), 64'd0);
            check_value("data_ack_o", 64'(data_ack_o), 64'd0);
            check_value("bus_p_ready_o", 64'(bus_p_ready_o), 64'd0);
        end
    endtask

    task automatic fetch_halves();
        logic [31:0] exp_half [4];
        logic [31:0] addr;
        logic [31:0] rd;
        exp_half = '{32'h89AB_CDEF, 32'h0123_4567, 32'h7654_3210, 32'hFEDC_BA98};
        preload(32'h1000, 64'h0123_4567_89AB_CDEF);
        preload(32'h1008, 64'hFEDC_BA98_7654_3210);
        for (int i = 0; i < 4; i++) begin
            addr = 32'h1000 + 32'(i * 4);
            fetch_word(addr, rd);
            check_value("inst_rdata_o", 64'(rd), 64'(exp_half[i]));
            check_value("bus_q_addr_o", 64'(last_addr), 64'({addr[31:3], 3'b000}));
            check_value("bus_q_op_o", 64'(last_op), 64'(BUS_READ));
            check_value("bus_q_size_o", 64'(last_size), 64'(BUS_SIZE_DWORD));
        end
    endtask

    task automatic store_load_words();
        logic [31:0] rd;
        logic        err;
        data_access(1'b1, 32'h100, 32'hDEAD_BEEF, 4'hF, rd, err);
        check_value("bus_q_op_o", 64'(last_op), 64'(BUS_WRITE));
        check_value("bus_q_size_o", 64'(last_size), 64'(BUS_SIZE_WORD));
        check_value("bus_q_strb_o", 64'(last_strb), 64'h0F);
        check_value("bus_q_wdata_o", last_wdata, 64'h0000_0000_DEAD_BEEF);
        data_access(1'b1, 32'h104, 32'h1234_5678, 4'hF, rd, err);
        check_value("bus_q_addr_o", 64'(last_addr), 64'h104);
        check_value("bus_q_strb_o", 64'(last_strb), 64'hF0);
        check_value("bus_q_wdata_o", last_wdata, 64'h1234_5678_0000_0000);
        data_access(1'b0, 32'h100, 32'h0, 4'h0, rd, err);
        check_value("bus_q_op_o", 64'(last_op), 64'(BUS_READ));
        check_value("data_rdata_o", 64'(rd), 64'hDEAD_BEEF);
        check_value("data_err_o", 64'(err), 64'd0);
        data_access(1'b0, 32'h104, 32'h0, 4'h0, rd, err);
        check_value("data_rdata_o", 64'(rd), 64'h1234_5678);
    endtask

    task automatic merge_partial_stores();
        logic [31:0] rd;
        logic        err;
        preload(32'h200, 64'h1122_3344_5566_7788);
        // Byte 1 of the lower word, then the upper halfword of the upper word
        data_access(1'b1, 32'h201, 32'h0000_AB00, 4'b0010, rd, err);
        check_value("bus_q_strb_o", 64'(last_strb), 64'h02);
        data_access(1'b1, 32'h206, 32'hCDEF_0000, 4'b1100, rd, err);
        check_value("bus_q_addr_o", 64'(last_addr), 64'h204);
        check_value("bus_q_strb_o", 64'(last_strb), 64'hC0);
        data_access(1'b0, 32'h200, 32'h0, 4'h0, rd, err);
        check_value("data_rdata_o", 64'(rd), 64'h5566_AB88);
        data_access(1'b0, 32'h204, 32'h0, 4'h0, rd, err);
        check_value("data_rdata_o", 64'(rd), 64'hCDEF_3344);
    endtask

    task automatic flag_bus_error();
        logic [31:0] rd;
        logic        err;
        data_access(1'b0, ERR_BASE + 32'h10, 32'h0, 4'h0, rd, err);
        check_value("data_err_o", 64'(err), 64'd1);
        check_value("data_rdata_o", 64'(rd), 64'd0);
        data_access(1'b0, 32'h100, 32'h0, 4'h0, rd, err);
        check_value("data_err_o", 64'(err), 64'd0);
        check_value("data_rdata_o", 64'(rd), 64'hDEAD_BEEF);
    endtask

    // Fetches stay in 0x1000-0x1fff and data in 0x2000-0x20ff, so order never matters
    task automatic mix_concurrent_traffic();
        logic [31:0] ir;
        logic [31:0] ia;
        logic [31:0] ird;
        logic [63:0] iw;
        logic [31:0] dr;
        logic [31:0] da;
        logic [31:0] dwd;
        logic [31:0] drd;
        logic [63:0] dw;
        logic        derr;
        fork
            begin
                for (int i = 0; i < CONC_OPS; i++) begin
                    ir = $random(seed);
                    ia = 32'h1000 + (ir & 32'h0000_0FFC);
                    fetch_word(ia, ird);
                    iw = ref_word(ia);
                    check_value("inst_rdata_o", 64'(ird), 64'(ia[2] ? iw[63:32] : iw[31:0]));
                end
            end
            begin
                for (int i = 0; i < CONC_OPS; i++) begin
                    dr = $random(seed);
                    da = 32'h2000 + (dr & 32'h0000_00FC);
                    if (dr[16]) begin
                        dwd = $random(seed);
                        data_access(1'b1, da, dwd, dr[23:20], drd, derr);
                        ref_store(da, dwd, dr[23:20]);
                    end else begin
                        data_access(1'b0, da, 32'h0, 4'h0, drd, derr);
                        dw = ref_word(da);
                        check_value("data_rdata_o", 64'(drd),
                                    64'(da[2] ? dw[63:32] : dw[31:0]));
                    end
                    check_value("data_err_o", 64'(derr), 64'd0);
                end
            end
        join
    endtask

    // --------------------
    // Sequence and watchdog
    // --------------------

    initial begin
        inst_req_i   = 1'b0;
        inst_addr_i  = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        data_strb_i  = '0;
        rst_ni       = 1'b0;
        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        check_reset_idle();
        fetch_halves();
        store_load_words();
        merge_partial_stores();
        flag_bus_error();
        mix_concurrent_traffic();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk_i);
        $display("Timeout: the tests did not finish within %0d cycles, %0d errors so far",
                 NUM_TESTS * CYCLES_PER_TEST, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/mem_bridge_pkg.sv
hw/inst_fetch_adapter.sv
hw/data_access_adapter.sv
hw/bus_arbiter.sv
hw/mem_bridge_top.sv
testbench/tb_mem_bridge.sv
